// ==== sim.f ====
+incdir+.
cpuSmPkg.sv
cpuSmInputs.sv
cpuSmSequencer.sv
cpuLaneCtrl.sv
cpuSmOutputs.sv
cpuSmTop.sv
tbCpuSm.sv

// ==== tbCpuSm.sv ====
`timescale 1ns/1ps
`include "cpuSm_params.svh"

module tbCpuSm;

    localparam int numWords = 200;
    // Two bus cycles of up to 16 clocks per word plus reset and flush slack
    localparam int cycleLimit = numWords * 2 * 16 + 1000;

    logic       CLK90;
    logic       CCRESET_;
    logic       dmaEna;
    logic       dmaReq;
    logic       dmaDir;
    logic       busGrant;
    logic       flushFifo;
    logic       fifoEmpty;
    logic       fifoFull;
    logic [1:0] dsack;
    logic       sterm;
    logic       busReq;
    logic       bgAck;
    logic       pAs;
    logic       pDs;
    logic       size1;
    logic       plhw;
    logic       pllw;
    logic       dieh;
    logic       diel;
    logic       f2cpuh;
    logic       f2cpul;
    logic       incFifo;
    logic       decFifo;
    logic       incAddr;
    logic       stopFlush;

    integer     seed;
    int         errors;
    int         checks;
    int         cycles;
    int         modelReads;
    int         modelWrites;
    int         incFifoCount;
    int         decFifoCount;
    logic       grantGiven;
    logic       force32;
    logic       bgAckPrev;
    logic       pDsPrev;
    logic       pAsPrev;
    logic       pAsPrev2;
    logic [5:0] laneSeen;
    logic       sizeSeen;
    // Bus cycle record {dir, size1, upper, lower, word done}
    logic [4:0] cycleQ[$];
    // Flush record is set when the flush must push a partial word
    logic       flushQueue[$];

    cpuSmTop u_dut (.*);

    initial CLK90 = 1'b0;
    always #5 CLK90 = ~CLK90;

    always @(posedge CLK90) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        errors++;
        $display("FAIL @ %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
    endtask

    task automatic reportProblem(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    function automatic int randBelow(input int n);
        randBelow = ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [14:0] outputsVector();
        outputsVector = {busReq, bgAck, pAs, pDs, size1, plhw, pllw, dieh, diel,
                         f2cpuh, f2cpul, incFifo, decFifo, incAddr, stopFlush};
    endfunction

    // Protocol checks and pulse bookkeeping for each clock
    always @(negedge CLK90) begin
        logic [4:0] rec;
        logic [5:0] lanesExp;
        logic       rd;
        if (pAs && !bgAck) begin
            reportProblem("pAs is high while bgAck is low");
        end
        if (bgAck && !bgAckPrev && !grantGiven) begin
            reportProblem("bgAck rose although the bus was never granted");
        end
        if (pDs && !pDsPrev && !(pAsPrev && !pAsPrev2)) begin
            reportProblem("pDs rose without pAs rising one cycle before");
        end
        if (pAsPrev && !pAsPrev2 && !pDs) begin
            reportProblem("pDs did not follow pAs after one cycle");
        end
        if (size1 && !pAs) begin
            reportProblem("size1 is high outside the address and data phases");
        end
        if (!pDs && (plhw || pllw || dieh || diel || f2cpuh || f2cpul)) begin
            reportProblem("a lane enable is high outside the data phase");
        end
        if (pAs) begin
            sizeSeen = sizeSeen | size1;
        end
        if (pDs) begin
            laneSeen = laneSeen | {plhw, pllw, dieh, diel, f2cpuh, f2cpul};
        end
        if (incFifo) begin
            incFifoCount++;
        end
        if (decFifo) begin
            decFifoCount++;
        end
        if (incAddr) begin
            checks++;
            if (cycleQ.size() == 0) begin
                reportProblem("incAddr pulsed with no bus cycle outstanding");
            end else begin
                rec = cycleQ.pop_front();
                rd = !rec[4];
                lanesExp = {rd & rec[2], rd & rec[1], rd & rec[2], rd & rec[1],
                            rec[4] & rec[2], rec[4] & rec[1]};
                if (laneSeen != lanesExp) begin
                    reportMismatch("lane enables", laneSeen, lanesExp);
                end
                if (sizeSeen != rec[3]) begin
                    reportMismatch("size1", sizeSeen, rec[3]);
                end
                if (incFifo != (rec[0] & rd)) begin
                    reportMismatch("incFifo", incFifo, rec[0] & rd);
                end
                if (decFifo != (rec[0] & rec[4])) begin
                    reportMismatch("decFifo", decFifo, rec[0] & rec[4]);
                end
            end
            laneSeen = '0;
            sizeSeen = 1'b0;
        end else if (stopFlush) begin
            checks++;
            if (flushQueue.size() == 0) begin
                reportProblem("stopFlush pulsed with no flush requested");
            end else begin
                rd = flushQueue.pop_front();
                if (incFifo != rd) begin
                    reportMismatch("incFifo on flush", incFifo, rd);
                end
                if (decFifo) begin
                    reportMismatch("decFifo on flush", decFifo, 0);
                end
            end
        end else if (incFifo || decFifo) begin
            reportProblem("FIFO pulse outside a lane update or a flush");
        end
        bgAckPrev = bgAck;
        pDsPrev = pDs;
        pAsPrev2 = pAsPrev;
        pAsPrev = pAs;
    end

    task automatic driveTermination(input logic port32);
        if (port32) begin
            if (randBelow(2) == 1) begin
                sterm = 1'b1;
            end else begin
                dsack = 2'b11;
            end
        end else if (randBelow(2) == 1) begin
            dsack = 2'b10;
        end else begin
            dsack = 2'b01;
        end
    endtask

    // One longword that may be held back by a FIFO flag and followed by a flush
    task automatic runWord();
        logic wr;
        logic doFlush;
        logic port32;
        logic upFilled;
        logic loFilled;
        logic upAct;
        logic loAct;
        logic oneLeft;
        logic done;
        logic cut;
        int   holdCycles;
        wr = (randBelow(2) == 1);
        doFlush = (randBelow(8) == 0);
        upFilled = 1'b0;
        loFilled = 1'b0;
        done = 1'b0;
        cut = 1'b0;
        @(negedge CLK90);
        dmaDir = wr;
        dmaReq = 1'b1;
        if (randBelow(4) == 0) begin
            fifoEmpty = wr;
            fifoFull = !wr;
            // Past the request latency so an ignored flag would show up
            holdCycles = 3 + randBelow(4);
            repeat (holdCycles) begin
                @(negedge CLK90);
                checks++;
                if (busReq) begin
                    reportProblem("bus requested while the FIFO flag blocks this direction");
                end
            end
            fifoEmpty = 1'b0;
            fifoFull = 1'b0;
        end
        while (!busReq) @(negedge CLK90);
        repeat (randBelow(6)) @(negedge CLK90);
        busGrant = 1'b1;
        grantGiven = 1'b1;
        while (!done && !cut) begin
            port32 = force32 ? 1'b1 : (randBelow(2) == 1);
            force32 = 1'b0;
            // 32-bit takes every open lane and 16-bit the upper lane first
            upAct = !upFilled;
            loAct = !loFilled && (port32 || upFilled);
            oneLeft = upFilled ^ loFilled;
            upFilled = upFilled | upAct;
            loFilled = loFilled | loAct;
            done = upFilled && loFilled;
            cut = doFlush && !wr && !done;
            while (!pDs) @(negedge CLK90);
            repeat (randBelow(7)) @(negedge CLK90);
            cycleQ.push_back({wr, oneLeft, upAct, loAct, done});
            driveTermination(port32);
            if (done || cut) begin
                dmaReq = 1'b0;
            end
            if (cut) begin
                flushFifo = 1'b1;
            end
            while (pDs) @(negedge CLK90);
            dsack = 2'b00;
            sterm = 1'b0;
        end
        if (cut) begin
            flushQueue.push_back(1'b1);
        end
        while (bgAck) @(negedge CLK90);
        busGrant = 1'b0;
        grantGiven = 1'b0;
        if (wr) begin
            modelWrites++;
        end else begin
            modelReads++;
        end
        if (cut) begin
            while (!stopFlush) @(negedge CLK90);
            flushFifo = 1'b0;
            force32 = 1'b1;
        end else if (doFlush && wr) begin
            // Write flush on an empty FIFO with the request held for one clock
            @(negedge CLK90);
            flushQueue.push_back(1'b0);
            fifoEmpty = 1'b1;
            flushFifo = 1'b1;
            @(negedge CLK90);
            flushFifo = 1'b0;
            while (!stopFlush) @(negedge CLK90);
            fifoEmpty = 1'b0;
        end
    endtask

    initial begin
        seed = 32'h06f5_0d9b;
        CCRESET_ = 1'b0;
        dmaEna = `CPUSM_SYNC_RST;
        dmaReq = `CPUSM_SYNC_RST;
        dmaDir = 1'b0;
        busGrant = `CPUSM_SYNC_RST;
        flushFifo = `CPUSM_SYNC_RST;
        fifoEmpty = `CPUSM_SYNC_RST;
        fifoFull = `CPUSM_SYNC_RST;
        dsack = 2'b00;
        sterm = 1'b0;
        grantGiven = 1'b0;
        force32 = 1'b0;
        bgAckPrev = 1'b0;
        pDsPrev = 1'b0;
        pAsPrev = 1'b0;
        pAsPrev2 = 1'b0;
        laneSeen = '0;
        sizeSeen = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge CLK90);
            checks++;
            if (outputsVector() != '0) begin
                reportMismatch("outputs in reset", outputsVector(), 0);
            end
        end
        CCRESET_ = 1'b1;
        dmaEna = 1'b1;
        @(negedge CLK90);
        checks++;
        if (outputsVector() != '0) begin
            reportMismatch("outputs after reset", outputsVector(), 0);
        end
        for (int w = 0; w < numWords; w++) begin
            runWord();
        end
        repeat (5) @(negedge CLK90);
        if (cycleQ.size() != 0 || flushQueue.size() != 0) begin
            reportProblem("expected bus cycle or flush pulses never arrived");
        end
        checks += 2;
        if (incFifoCount != modelReads) begin
            reportMismatch("incFifo pulse count", incFifoCount, modelReads);
        end
        if (decFifoCount != modelWrites) begin
            reportMismatch("decFifo pulse count", decFifoCount, modelWrites);
        end
        $display("checks %0d, errors %0d, read words %0d, write words %0d",
                 checks, errors, modelReads, modelWrites);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== cpuSmTop.sv ====
`timescale 1ns/1ps
`include "cpuSm_params.svh"

module cpuSmTop (
    input  logic       CLK90,
    input  logic       CCRESET_,
    input  logic       dmaEna,
    input  logic       dmaReq,
    input  logic       dmaDir,
    input  logic       busGrant,
    input  logic       flushFifo,
    input  logic       fifoEmpty,
    input  logic       fifoFull,
    input  logic [1:0] dsack,
    input  logic       sterm,
    output logic       busReq,
    output logic       bgAck,
    output logic       pAs,
    output logic       pDs,
    output logic       size1,
    output logic       plhw,
    output logic       pllw,
    output logic       dieh,
    output logic       diel,
    output logic       f2cpuh,
    output logic       f2cpul,
    output logic       incFifo,
    output logic       decFifo,
    output logic       incAddr,
    output logic       stopFlush
);

    logic enaQ;
    logic reqQ;
    logic grantQ;
    logic flushQ;
    logic emptyQ;
    logic fullQ;
    logic dir;
    logic pDsReq;
    logic laneStep;
    logic wordClear;
    logic wordFull;
    logic anyFilled;
    cpuSmPkg::termCode_t term;
    cpuSmPkg::cpuState_t state;
    cpuSmPkg::laneMask_t filled;
    cpuSmPkg::laneMask_t active;

    cpuSmInputs uInputs (
        .CLK90     (CLK90),
        .CCRESET_  (CCRESET_),
        .dmaEna    (dmaEna),
        .dmaReq    (dmaReq),
        .busGrant  (busGrant),
        .flushFifo (flushFifo),
        .fifoEmpty (fifoEmpty),
        .fifoFull  (fifoFull),
        .dsack     (dsack),
        .sterm     (sterm),
        .pDsReq    (pDsReq),
        .enaQ      (enaQ),
        .reqQ      (reqQ),
        .grantQ    (grantQ),
        .flushQ    (flushQ),
        .emptyQ    (emptyQ),
        .fullQ     (fullQ),
        .term      (term)
    );

    cpuSmSequencer uSequencer (
        .CLK90     (CLK90),
        .CCRESET_  (CCRESET_),
        .enaQ      (enaQ),
        .reqQ      (reqQ),
        .grantQ    (grantQ),
        .flushQ    (flushQ),
        .emptyQ    (emptyQ),
        .fullQ     (fullQ),
        .dmaDir    (dmaDir),
        .term      (term),
        .wordFull  (wordFull),
        .anyFilled (anyFilled),
        .state     (state),
        .dir       (dir),
        .pDsReq    (pDsReq),
        .laneStep  (laneStep),
        .wordClear (wordClear)
    );

    // Highest index is the upper lane, each lane watches its partner
    for (genvar i = 0; i < `CPUSM_LANES; i++) begin : gLane
        cpuLaneCtrl uLane (
            .CLK90       (CLK90),
            .CCRESET_    (CCRESET_),
            .upper       (i == `CPUSM_LANES - 1),
            .state       (state),
            .dir         (dir),
            .term        (term),
            .laneStep    (laneStep),
            .wordClear   (wordClear),
            .otherFilled (filled[`CPUSM_LANES - 1 - i]),
            .filled      (filled[i]),
            .active      (active[i])
        );
    end

    cpuSmOutputs uOutputs (
        .CLK90     (CLK90),
        .CCRESET_  (CCRESET_),
        .state     (state),
        .dir       (dir),
        .filled    (filled),
        .active    (active),
        .wordFull  (wordFull),
        .anyFilled (anyFilled),
        .busReq    (busReq),
        .bgAck     (bgAck),
        .pAs       (pAs),
        .pDs       (pDs),
        .size1     (size1),
        .plhw      (plhw),
        .pllw      (pllw),
        .dieh      (dieh),
        .diel      (diel),
        .f2cpuh    (f2cpuh),
        .f2cpul    (f2cpul),
        .incFifo   (incFifo),
        .decFifo   (decFifo),
        .incAddr   (incAddr),
        .stopFlush (stopFlush)
    );

endmodule

// ==== cpuSmOutputs.sv ====
`timescale 1ns/1ps
`include "cpuSm_params.svh"

module cpuSmOutputs (
    input  logic                CLK90,
    input  logic                CCRESET_,
    input  cpuSmPkg::cpuState_t state,
    input  logic                dir,
    input  cpuSmPkg::laneMask_t filled,
    input  cpuSmPkg::laneMask_t active,
    output logic                wordFull,
    output logic                anyFilled,
    output logic                busReq,
    output logic                bgAck,
    output logic                pAs,
    output logic                pDs,
    output logic                size1,
    output logic                plhw,
    output logic                pllw,
    output logic                dieh,
    output logic                diel,
    output logic                f2cpuh,
    output logic                f2cpul,
    output logic                incFifo,
    output logic                decFifo,
    output logic                incAddr,
    output logic                stopFlush
);

    localparam int Hi = `CPUSM_LANES - 1;

    logic addrPh;
    logic dataPh;
    logic lanePh;
    logic flushPh;
    logic oneOpen;
    logic wordDone;
    logic readHi;
    logic readLo;

    assign wordFull  = &filled;
    assign anyFilled = |filled;

    // Only one halfword left to move
    assign oneOpen = ($countones(~filled) == 1);

    // This bus cycle finishes the longword
    assign wordDone = &(filled | active);

    assign addrPh  = (state == cpuSmPkg::smAddr);
    assign dataPh  = (state == cpuSmPkg::smData);
    assign lanePh  = (state == cpuSmPkg::smLane);
    assign flushPh = (state == cpuSmPkg::smFlush);

    assign readHi = dataPh & !dir & active[Hi];
    assign readLo = dataPh & !dir & active[0];

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            busReq    <= 1'b0;
            bgAck     <= 1'b0;
            pAs       <= 1'b0;
            pDs       <= 1'b0;
            size1     <= 1'b0;
            plhw      <= 1'b0;
            pllw      <= 1'b0;
            dieh      <= 1'b0;
            diel      <= 1'b0;
            f2cpuh    <= 1'b0;
            f2cpul    <= 1'b0;
            incFifo   <= 1'b0;
            decFifo   <= 1'b0;
            incAddr   <= 1'b0;
            stopFlush <= 1'b0;
        end else begin
            busReq    <= (state == cpuSmPkg::smBusReq);
            bgAck     <= addrPh | dataPh | lanePh | (state == cpuSmPkg::smRelease);
            pAs       <= addrPh | dataPh;
            pDs       <= dataPh;
            size1     <= (addrPh | dataPh) & oneOpen;
            // Read latches bus data into the FIFO halves
            plhw      <= readHi;
            pllw      <= readLo;
            dieh      <= readHi;
            diel      <= readLo;
            // Write puts FIFO halves onto the bus
            f2cpuh    <= dataPh & dir & active[Hi];
            f2cpul    <= dataPh & dir & active[0];
            incFifo   <= (lanePh & wordDone & !dir) | (flushPh & !dir & anyFilled);
            decFifo   <= lanePh & wordDone & dir;
            incAddr   <= lanePh;
            stopFlush <= flushPh;
        end
    end

endmodule

// ==== cpuLaneCtrl.sv ====
`timescale 1ns/1ps

module cpuLaneCtrl (
    input  logic                CLK90,
    input  logic                CCRESET_,
    input  logic                upper,
    input  cpuSmPkg::cpuState_t state,
    input  logic                dir,
    input  cpuSmPkg::termCode_t term,
    input  logic                laneStep,
    input  logic                wordClear,
    input  logic                otherFilled,
    output logic                filled,
    output logic                active
);

    logic filledQ;
    logic fillDir;
    logic inCycle;
    logic myTurn;

    // Lane decisions only matter once the port size is known
    assign inCycle = (state == cpuSmPkg::smData) || (state == cpuSmPkg::smLane);

    // 32-bit port serves every open lane
    // 16-bit port serves the upper lane first, lower once upper is done
    assign myTurn = term[0] | upper | otherFilled;

    // A halfword left over from the other direction does not count
    assign filled = filledQ & (fillDir == dir);

    assign active = term[1] & inCycle & !filled & myTurn;

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            filledQ <= 1'b0;
            fillDir <= 1'b0;
        end else if (wordClear) begin
            filledQ <= 1'b0;
        end else if (laneStep && active) begin
            filledQ <= 1'b1;
            fillDir <= dir;
        end
    end

endmodule

// ==== cpuSmSequencer.sv ====
`timescale 1ns/1ps

module cpuSmSequencer (
    input  logic                CLK90,
    input  logic                CCRESET_,
    input  logic                enaQ,
    input  logic                reqQ,
    input  logic                grantQ,
    input  logic                flushQ,
    input  logic                emptyQ,
    input  logic                fullQ,
    input  logic                dmaDir,
    input  cpuSmPkg::termCode_t term,
    input  logic                wordFull,
    input  logic                anyFilled,
    output cpuSmPkg::cpuState_t state,
    output logic                dir,
    output logic                pDsReq,
    output logic                laneStep,
    output logic                wordClear
);

    cpuSmPkg::cpuState_t nextState;
    logic fifoReady;
    logic flushNow;
    logic cutShort;
    logic leaveIdle;

    // Read fills the FIFO so it must not be full
    // Write drains it so it must not be empty
    assign fifoReady = dmaDir ? !emptyQ : !fullQ;

    // Write flush once the FIFO has run dry
    // Read flush only with a partial word to push
    assign flushNow = flushQ & (dmaDir ? emptyQ : anyFilled);

    // A flush during a read stops the word after the current halfword
    assign cutShort = flushQ & !dir;

    always_comb begin
        nextState = state;
        case (state)
            cpuSmPkg::smIdle: begin
                if (flushNow) begin
                    nextState = cpuSmPkg::smFlush;
                end else if (enaQ && reqQ && fifoReady) begin
                    nextState = cpuSmPkg::smBusReq;
                end
            end
            // Hold the request until the arbiter grants the bus
            cpuSmPkg::smBusReq: begin
                if (grantQ) begin
                    nextState = cpuSmPkg::smAddr;
                end
            end
            cpuSmPkg::smAddr: begin
                nextState = cpuSmPkg::smData;
            end
            // Wait states last until a termination is latched
            cpuSmPkg::smData: begin
                if (term[1]) begin
                    nextState = cpuSmPkg::smLane;
                end
            end
            cpuSmPkg::smLane: begin
                nextState = cpuSmPkg::smRelease;
            end
            cpuSmPkg::smRelease: begin
                if (wordFull || cutShort) begin
                    nextState = cpuSmPkg::smIdle;
                end else begin
                    // Remaining halfword, bus is kept
                    nextState = cpuSmPkg::smAddr;
                end
            end
            cpuSmPkg::smFlush: begin
                nextState = cpuSmPkg::smIdle;
            end
            default: begin
                nextState = cpuSmPkg::smIdle;
            end
        endcase
    end

    assign leaveIdle = (state == cpuSmPkg::smIdle) && (nextState != cpuSmPkg::smIdle);

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state <= cpuSmPkg::smIdle;
        end else begin
            state <= nextState;
        end
    end

    // Direction stays fixed for the whole word
    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dir <= 1'b0;
        end else if (leaveIdle) begin
            dir <= dmaDir;
        end
    end

    assign pDsReq = (state == cpuSmPkg::smData);

    // Lane flags update at the end of the lane state
    assign laneStep = (state == cpuSmPkg::smLane);

    // Empty the lanes once the word has gone or been flushed
    assign wordClear = ((state == cpuSmPkg::smRelease) && wordFull)
                     || (state == cpuSmPkg::smFlush);

endmodule

// ==== cpuSmInputs.sv ====
`timescale 1ns/1ps
`include "cpuSm_params.svh"

module cpuSmInputs (
    input  logic                CLK90,
    input  logic                CCRESET_,
    input  logic                dmaEna,
    input  logic                dmaReq,
    input  logic                busGrant,
    input  logic                flushFifo,
    input  logic                fifoEmpty,
    input  logic                fifoFull,
    input  logic [1:0]          dsack,
    input  logic                sterm,
    input  logic                pDsReq,
    output logic                enaQ,
    output logic                reqQ,
    output logic                grantQ,
    output logic                flushQ,
    output logic                emptyQ,
    output logic                fullQ,
    output cpuSmPkg::termCode_t term
);

    logic termSeen;
    logic port32;

    // Any DSACK code or STERM ends the data phase
    assign termSeen = (|dsack) | sterm;

    // Both DSACK lines or STERM mean a 32-bit port
    assign port32 = (&dsack) | sterm;

    // One register stage for each asynchronous level
    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            enaQ   <= `CPUSM_SYNC_RST;
            reqQ   <= `CPUSM_SYNC_RST;
            grantQ <= `CPUSM_SYNC_RST;
            flushQ <= `CPUSM_SYNC_RST;
            emptyQ <= `CPUSM_SYNC_RST;
            fullQ  <= `CPUSM_SYNC_RST;
        end else begin
            enaQ   <= dmaEna;
            reqQ   <= dmaReq;
            grantQ <= busGrant;
            flushQ <= flushFifo;
            emptyQ <= fifoEmpty;
            fullQ  <= fifoFull;
        end
    end

    // Port size is captured on the first termination of the data phase
    // and held until the data strobe request goes away
    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            term <= '0;
        end else if (!pDsReq) begin
            term <= '0;
        end else if (!term[1] && termSeen) begin
            term <= {1'b1, port32};
        end
    end

endmodule

// ==== cpuSmPkg.sv ====
`include "cpuSm_params.svh"

package cpuSmPkg;

    // Bus-cycle sequencer states
    typedef enum logic [2:0] {
        smIdle    = 3'd0,
        smBusReq  = 3'd1,
        smAddr    = 3'd2,
        smData    = 3'd3,
        smLane    = 3'd4,
        smRelease = 3'd5,
        smFlush   = 3'd6
    } cpuState_t;

    // Latched termination code
    // Bit 1 set once the cycle is terminated
    // Bit 0 set for a 32-bit port
    typedef logic [1:0] termCode_t;

    // One flag per halfword lane
    // Bit 1 is the upper lane (A1 low) and bit 0 the lower lane
    typedef logic [`CPUSM_LANES-1:0] laneMask_t;

endpackage

// ==== cpuSm_params.svh ====
`ifndef CPUSM_PARAMS_SVH
`define CPUSM_PARAMS_SVH

// Halfword lanes in one longword
`define CPUSM_LANES 2

// Value of the registered active-high inputs while in reset
`define CPUSM_SYNC_RST 1'b0

`endif
